// File: design/mcu_cfg.svh
// --------------------------------------------------------------------------
// Widths and depths of the memory command unit, shared with the testbench
// Queue depths must be powers of two for the wrap-bit pointer scheme
// MCU_RSP_CREDITS must not exceed MCU_RSP_DEPTH
// --------------------------------------------------------------------------
`ifndef MCU_CFG_SVH
`define MCU_CFG_SVH

// Word address on the memory port
`define MCU_ADDR_W 16

// Data word and its byte strobes
`define MCU_DATA_W 32
`define MCU_STRB_W 4

// Requester tag carried back in every response
`define MCU_TAG_W 8

// Request queue depth, also the requester's initial credit count
`define MCU_REQ_DEPTH 8

// Response queue depth
`define MCU_RSP_DEPTH 8

// Response credits held at reset
// One credit per response queue slot
`define MCU_RSP_CREDITS `MCU_RSP_DEPTH

`endif

// File: design/mcu_pkg.sv
// --------------------------------------------------------------------------
// Command, operand and FSM types of the memory command unit
// Operand layout is tied to MCU_DATA_W, MCU_STRB_W and MCU_TAG_W
// --------------------------------------------------------------------------
`include "mcu_cfg.svh"

package mcu_pkg;

  // Single-bit command code
  typedef enum logic {
    CMD_READ  = 1'b0,
    CMD_WRITE = 1'b1
  } mcu_cmd_e;

  // Write view of the operand word
  typedef struct packed {
    logic [`MCU_DATA_W-1:0] wdata;
    logic [`MCU_STRB_W-1:0] wstrb;
  } mcu_wr_view_t;

  // Read view of the operand word
  // Mask sits where the strobes sit, ignored by the unit
  typedef struct packed {
    logic [`MCU_TAG_W-1:0]            tag;
    logic [`MCU_DATA_W-`MCU_TAG_W-1:0] pad;
    logic [`MCU_STRB_W-1:0]           mask;
  } mcu_rd_view_t;

  // Same 36-bit word, decoded by command
  typedef union packed {
    mcu_wr_view_t wr;
    mcu_rd_view_t rd;
  } mcu_operand_u;

  // One request queue entry
  typedef struct packed {
    mcu_cmd_e               cmd;
    logic [`MCU_ADDR_W-1:0] offset;
    logic [`MCU_TAG_W-1:0]  tag;
    mcu_operand_u           operand;
  } mcu_req_t;

  // Issue FSM states
  typedef enum logic [1:0] {IDLE, ISSUE, WAIT} mcu_state_e;

endpackage

// File: design/mcu_decode.sv
// --------------------------------------------------------------------------
// Descriptor base, request queue and requester credit return
// Requester must hold a credit for every req_valid, queue has no full check
// Commands stay queued until a descriptor has been loaded
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`include "mcu_cfg.svh"

module mcu_decode import mcu_pkg::*; (
  input  logic                   ap_clk,
  input  logic                   areset_control,
  // Descriptor
  input  logic                   cfg_valid,
  input  logic [`MCU_ADDR_W-1:0] cfg_base,
  // Request side
  input  logic                   req_valid,
  input  mcu_cmd_e               req_cmd,
  input  logic [`MCU_ADDR_W-1:0] req_offset,
  input  logic [`MCU_TAG_W-1:0]  req_tag,
  input  mcu_operand_u           req_operand,
  // Queue head toward execute
  input  logic                   pop,
  output logic                   head_valid,
  output mcu_req_t               head,
  output logic [`MCU_ADDR_W-1:0] head_addr,
  output logic                   req_credit,
  output logic                   req_empty
);

  localparam int PTR_W = $clog2(`MCU_REQ_DEPTH);

  logic [`MCU_ADDR_W-1:0] base_q;
  logic                   base_loaded;
  mcu_req_t               req_word;
  mcu_req_t               queue_mem [`MCU_REQ_DEPTH];
  // Extra MSB tells full from empty
  logic [PTR_W:0]         wr_ptr;
  logic [PTR_W:0]         rd_ptr;

  // --------------------------------------------------------------------------
  // Descriptor
  // --------------------------------------------------------------------------
  // Loaded flag opens the queue head
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      base_loaded <= 1'b0;
    end else if (cfg_valid) begin
      base_loaded <= 1'b1;
    end
  end

  // Base value, reloadable by a later descriptor
  always_ff @(posedge ap_clk) begin
    if (cfg_valid) begin
      base_q <= cfg_base;
    end
  end

  // --------------------------------------------------------------------------
  // Request queue
  // --------------------------------------------------------------------------
  // Pack loose request ports into one entry
  always_comb begin
    req_word.cmd     = req_cmd;
    req_word.offset  = req_offset;
    req_word.tag     = req_tag;
    req_word.operand = req_operand;
  end

  // Entry written in the cycle req_valid is seen
  always_ff @(posedge ap_clk) begin
    if (req_valid) begin
      queue_mem[wr_ptr[PTR_W-1:0]] <= req_word;
    end
  end

  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (req_valid) begin
        wr_ptr <= wr_ptr + (PTR_W+1)'(1);
      end
      if (pop) begin
        rd_ptr <= rd_ptr + (PTR_W+1)'(1);
      end
    end
  end

  assign req_empty = (wr_ptr == rd_ptr);

  // Head visible only once a descriptor is in
  assign head       = queue_mem[rd_ptr[PTR_W-1:0]];
  assign head_valid = ~req_empty & base_loaded;
  // Word address, wraps at the port width
  assign head_addr  = base_q + head.offset;

  // One credit back per popped entry, a cycle late
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      req_credit <= 1'b0;
    end else begin
      req_credit <= pop;
    end
  end

endmodule

// File: design/mcu_execute.sv
// --------------------------------------------------------------------------
// Issue FSM and single-beat memory port driver
// One access in flight, started only while a response credit is held
// mem_done is expected no earlier than the cycle after mem_req
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`include "mcu_cfg.svh"

module mcu_execute import mcu_pkg::*; (
  input  logic                   ap_clk,
  input  logic                   areset_control,
  // Queue head from decode
  input  logic                   head_valid,
  input  mcu_req_t               head,
  input  logic [`MCU_ADDR_W-1:0] head_addr,
  // Consumer credit return
  input  logic                   rsp_credit,
  input  logic                   mem_done,
  output logic                   pop,
  // Memory port
  output logic                   mem_req,
  output logic                   mem_we,
  output logic [`MCU_ADDR_W-1:0] mem_addr,
  output logic [`MCU_DATA_W-1:0] mem_wdata,
  output logic [`MCU_STRB_W-1:0] mem_wstrb,
  // Completion toward result
  output logic                   done_valid,
  output logic [`MCU_TAG_W-1:0]  done_tag,
  output mcu_cmd_e               done_cmd,
  output logic [`MCU_DATA_W-1:0] done_wdata,
  output logic                   exec_busy
);

  localparam int CRD_W = $clog2(`MCU_RSP_CREDITS + 1);

  mcu_state_e             state;
  mcu_state_e             state_nxt;
  logic [CRD_W-1:0]       credit_cnt;
  logic                   has_credit;
  logic                   launch;
  logic                   take_credit;
  logic [`MCU_DATA_W-1:0] head_wdata;
  logic [`MCU_STRB_W-1:0] head_wstrb;
  logic [`MCU_TAG_W-1:0]  head_tag;
  logic [`MCU_TAG_W-1:0]  issue_tag;
  mcu_cmd_e               issue_cmd;

  // --------------------------------------------------------------------------
  // Operand decode
  // --------------------------------------------------------------------------
  // Writes use the write view and the struct tag
  // Reads take the tag from the read view, strobes forced low
  always_comb begin
    if (head.cmd == CMD_WRITE) begin
      head_wdata = head.operand.wr.wdata;
      head_wstrb = head.operand.wr.wstrb;
      head_tag   = head.tag;
    end else begin
      head_wdata = '0;
      head_wstrb = '0;
      head_tag   = head.operand.rd.tag;
    end
  end

  // --------------------------------------------------------------------------
  // Issue FSM
  // --------------------------------------------------------------------------
  assign has_credit = (credit_cnt != '0);

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE:    if (head_valid && has_credit) state_nxt = ISSUE;
      ISSUE:   state_nxt = WAIT;
      WAIT:    if (mem_done) state_nxt = IDLE;
      default: state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      state <= IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  assign launch      = (state == IDLE) && (state_nxt == ISSUE);
  assign take_credit = (state == ISSUE);

  // Pop and request share the ISSUE cycle
  assign pop     = (state == ISSUE);
  assign mem_req = (state == ISSUE);
  assign mem_we  = (issue_cmd == CMD_WRITE);

  // Access fields held from ISSUE until the next launch
  always_ff @(posedge ap_clk) begin
    if (launch) begin
      mem_addr  <= head_addr;
      mem_wdata <= head_wdata;
      mem_wstrb <= head_wstrb;
      issue_tag <= head_tag;
      issue_cmd <= head.cmd;
    end
  end

  // --------------------------------------------------------------------------
  // Response credits
  // --------------------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      credit_cnt <= CRD_W'(`MCU_RSP_CREDITS);
    end else begin
      case ({take_credit, rsp_credit})
        2'b10:   credit_cnt <= credit_cnt - CRD_W'(1);
        2'b01:   credit_cnt <= credit_cnt + CRD_W'(1);
        default: credit_cnt <= credit_cnt;
      endcase
    end
  end

  // Completion one cycle after mem_done
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      done_valid <= 1'b0;
    end else begin
      done_valid <= (state == WAIT) && mem_done;
    end
  end

  assign done_tag   = issue_tag;
  assign done_cmd   = issue_cmd;
  assign done_wdata = mem_wdata;
  // Covers the hand-off cycle before the response is queued
  assign exec_busy  = (state != IDLE) || done_valid;

endmodule

// File: design/mcu_result.sv
// --------------------------------------------------------------------------
// Response queue and idle status
// Drained one entry per cycle, the consumer's credits guarantee room
// mem_rdata is sampled every cycle and used one cycle after mem_done
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`include "mcu_cfg.svh"

module mcu_result import mcu_pkg::*; (
  input  logic                   ap_clk,
  input  logic                   areset_control,
  // Completion from execute
  input  logic                   done_valid,
  input  logic [`MCU_TAG_W-1:0]  done_tag,
  input  mcu_cmd_e               done_cmd,
  input  logic [`MCU_DATA_W-1:0] done_wdata,
  input  logic [`MCU_DATA_W-1:0] mem_rdata,
  // Status from the other blocks
  input  logic                   exec_busy,
  input  logic                   pop_empty_hint,
  // Response side
  output logic                   rsp_valid,
  output logic [`MCU_TAG_W-1:0]  rsp_tag,
  output logic [`MCU_DATA_W-1:0] rsp_data,
  output logic                   idle
);

  localparam int PTR_W   = $clog2(`MCU_RSP_DEPTH);
  localparam int ENTRY_W = `MCU_TAG_W + `MCU_DATA_W;

  logic [`MCU_DATA_W-1:0] rdata_q;
  logic [`MCU_DATA_W-1:0] sel_data;
  logic [ENTRY_W-1:0]     rsp_mem [`MCU_RSP_DEPTH];
  // Extra MSB tells full from empty
  logic [PTR_W:0]         wr_ptr;
  logic [PTR_W:0]         rd_ptr;
  logic                   rsp_empty;
  logic                   rsp_pop;

  // --------------------------------------------------------------------------
  // Data selection
  // --------------------------------------------------------------------------
  // Read data lands in the mem_done cycle, done_valid follows
  always_ff @(posedge ap_clk) begin
    rdata_q <= mem_rdata;
  end

  // Reads return memory data, writes echo their data
  assign sel_data = (done_cmd == CMD_READ) ? rdata_q : done_wdata;

  // --------------------------------------------------------------------------
  // Response queue
  // --------------------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (done_valid) begin
      rsp_mem[wr_ptr[PTR_W-1:0]] <= {done_tag, sel_data};
    end
  end

  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (done_valid) begin
        wr_ptr <= wr_ptr + (PTR_W+1)'(1);
      end
      if (rsp_pop) begin
        rd_ptr <= rd_ptr + (PTR_W+1)'(1);
      end
    end
  end

  assign rsp_empty = (wr_ptr == rd_ptr);

  // Head leaves whenever present
  assign rsp_pop               = ~rsp_empty;
  assign rsp_valid             = rsp_pop;
  assign {rsp_tag, rsp_data}   = rsp_mem[rd_ptr[PTR_W-1:0]];

  // --------------------------------------------------------------------------
  // Idle flag
  // --------------------------------------------------------------------------
  // Both queues empty and nothing on the memory port
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      idle <= 1'b1;
    end else begin
      idle <= pop_empty_hint & rsp_empty & ~exec_busy;
    end
  end

endmodule

// File: design/mcu_top.sv
// --------------------------------------------------------------------------
// Memory command unit top level
// Requester starts with MCU_REQ_DEPTH credits, unit with MCU_RSP_CREDITS
// Responses come back in issue order
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`include "mcu_cfg.svh"

module mcu_top import mcu_pkg::*; (
  input  logic                   ap_clk,
  input  logic                   areset_control,
  // Descriptor
  input  logic                   cfg_valid,
  input  logic [`MCU_ADDR_W-1:0] cfg_base,
  // Request side
  input  logic                   req_valid,
  input  mcu_cmd_e               req_cmd,
  input  logic [`MCU_ADDR_W-1:0] req_offset,
  input  logic [`MCU_TAG_W-1:0]  req_tag,
  input  mcu_operand_u           req_operand,
  output logic                   req_credit,
  // Response side
  output logic                   rsp_valid,
  output logic [`MCU_TAG_W-1:0]  rsp_tag,
  output logic [`MCU_DATA_W-1:0] rsp_data,
  input  logic                   rsp_credit,
  // Memory port
  output logic                   mem_req,
  output logic                   mem_we,
  output logic [`MCU_ADDR_W-1:0] mem_addr,
  output logic [`MCU_DATA_W-1:0] mem_wdata,
  output logic [`MCU_STRB_W-1:0] mem_wstrb,
  input  logic                   mem_done,
  input  logic [`MCU_DATA_W-1:0] mem_rdata,
  output logic                   idle
);

  // Decode to execute
  logic                   head_valid;
  mcu_req_t               head;
  logic [`MCU_ADDR_W-1:0] head_addr;
  logic                   pop;
  logic                   req_empty;
  // Execute to result
  logic                   done_valid;
  logic [`MCU_TAG_W-1:0]  done_tag;
  mcu_cmd_e               done_cmd;
  logic [`MCU_DATA_W-1:0] done_wdata;
  logic                   exec_busy;

  mcu_decode decode_i (
    .ap_clk, .areset_control, .cfg_valid, .cfg_base,
    .req_valid, .req_cmd, .req_offset, .req_tag, .req_operand,
    .pop, .head_valid, .head, .head_addr, .req_credit, .req_empty
  );

  mcu_execute execute_i (
    .ap_clk, .areset_control, .head_valid, .head, .head_addr, .rsp_credit, .mem_done,
    .pop, .mem_req, .mem_we, .mem_addr, .mem_wdata, .mem_wstrb,
    .done_valid, .done_tag, .done_cmd, .done_wdata, .exec_busy
  );

  mcu_result result_i (
    .ap_clk, .areset_control, .done_valid, .done_tag, .done_cmd, .done_wdata,
    .mem_rdata, .exec_busy, .pop_empty_hint(req_empty),
    .rsp_valid, .rsp_tag, .rsp_data, .idle
  );

endmodule

// File: bench/mcu_properties.sv
// --------------------------------------------------------------------------
// Concurrent checks bound into the issue FSM
// Credit limit, single access in flight, pop only behind a valid head
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`include "mcu_cfg.svh"

module mcu_properties (
  input  logic                                    ap_clk,
  input  logic                                    areset_control,
  input  logic [$clog2(`MCU_RSP_CREDITS + 1)-1:0] credit_cnt,
  input  logic                                    mem_req,
  input  logic                                    mem_done,
  input  logic                                    pop,
  input  logic                                    head_valid
);

  int unsigned credit_errs = 0;
  int unsigned overlap_errs = 0;
  int unsigned pop_errs = 0;
  int unsigned fail_count;
  logic        in_flight;

  // Summed for the testbench's final count
  assign fail_count = credit_errs + overlap_errs + pop_errs;

  // Access outstanding from mem_req until mem_done
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      in_flight <= 1'b0;
    end else if (mem_req) begin
      in_flight <= 1'b1;
    end else if (mem_done) begin
      in_flight <= 1'b0;
    end
  end

  // Never more credits than response queue slots
  credit_limit: assert property (@(posedge ap_clk) disable iff (areset_control)
    credit_cnt <= `MCU_RSP_CREDITS)
    else begin
      credit_errs++;
      $error("response credit count %0d above its limit", credit_cnt);
    end

  // No second request while one is open
  single_access: assert property (@(posedge ap_clk) disable iff (areset_control)
    mem_req |-> !in_flight)
    else begin
      overlap_errs++;
      $error("mem_req raised again before mem_done");
    end

  pop_gated: assert property (@(posedge ap_clk) disable iff (areset_control)
    pop |-> head_valid)
    else begin
      pop_errs++;
      $error("pop without head_valid");
    end

endmodule

bind mcu_execute mcu_properties props_i (
  .ap_clk(ap_clk), .areset_control(areset_control), .credit_cnt(credit_cnt),
  .mem_req(mem_req), .mem_done(mem_done), .pop(pop), .head_valid(head_valid)
);

// File: bench/mcu_tb.sv
// --------------------------------------------------------------------------
// Testbench for the memory command unit
// Memory model answers in 1 to 4 cycles, consumer returns credits with gaps
// Offsets stay below 32 so reads hit earlier writes, base is loaded once
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`include "mcu_cfg.svh"

module mcu_tb import mcu_pkg::*;;

  localparam int NUM_CMDS       = 200;
  localparam int CYCLES_PER_CMD = 20;
  localparam int MAX_CYCLES     = NUM_CMDS * CYCLES_PER_CMD;
  localparam int RSP_W          = `MCU_TAG_W + `MCU_DATA_W;

  logic                   ap_clk;
  logic                   areset_control;
  logic                   cfg_valid;
  logic [`MCU_ADDR_W-1:0] cfg_base;
  logic                   req_valid;
  mcu_cmd_e               req_cmd;
  logic [`MCU_ADDR_W-1:0] req_offset;
  logic [`MCU_TAG_W-1:0]  req_tag;
  mcu_operand_u           req_operand;
  logic                   req_credit;
  logic                   rsp_valid;
  logic [`MCU_TAG_W-1:0]  rsp_tag;
  logic [`MCU_DATA_W-1:0] rsp_data;
  logic                   rsp_credit;
  logic                   mem_req;
  logic                   mem_we;
  logic [`MCU_ADDR_W-1:0] mem_addr;
  logic [`MCU_DATA_W-1:0] mem_wdata;
  logic [`MCU_STRB_W-1:0] mem_wstrb;
  logic                   mem_done;
  logic [`MCU_DATA_W-1:0] mem_rdata;
  logic                   idle;

  // Memory behind the port and its reference copy
  logic [`MCU_DATA_W-1:0] mem_model [2**`MCU_ADDR_W];
  logic [`MCU_DATA_W-1:0] shadow [2**`MCU_ADDR_W];
  logic [RSP_W-1:0]       expected [$];
  logic [`MCU_ADDR_W-1:0] cur_base;
  logic                   hold_credits;
  int errors = 0;
  int sent = 0;
  int issued = 0;
  int rsp_count = 0;
  int credits_back = 0;
  int credit_pulses = 0;
  int req_credits = `MCU_REQ_DEPTH;

  mcu_top dut_i (.*);

  initial ap_clk = 1'b0;
  always #4 ap_clk = ~ap_clk;

  // Power-up contents, distinct for every address
  function automatic logic [`MCU_DATA_W-1:0] fill_word(logic [`MCU_ADDR_W-1:0] a);
    return {a, ~a} ^ 32'h6b43_a9b5;
  endfunction

  // Bytewise strobe merge
  function automatic logic [`MCU_DATA_W-1:0] merge_bytes(logic [`MCU_DATA_W-1:0] old_word,
      logic [`MCU_DATA_W-1:0] new_word, logic [`MCU_STRB_W-1:0] strb);
    logic [`MCU_DATA_W-1:0] res;
    int b;
    res = old_word;
    for (b = 0; b < `MCU_STRB_W; b++) begin
      if (strb[b]) begin
        res[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return res;
  endfunction

  // Writes echo tag and data, reads return the read-view tag and stored word
  function automatic logic [RSP_W-1:0] expect_rsp(mcu_cmd_e cmd, logic [`MCU_ADDR_W-1:0] addr,
      logic [`MCU_TAG_W-1:0] tag, mcu_operand_u op);
    if (cmd == CMD_WRITE) begin
      return {tag, op.wr.wdata};
    end
    return {op.rd.tag, shadow[addr]};
  endfunction

  task automatic flag_mismatch(string name, logic [31:0] exp_v, logic [31:0] act_v);
    $display("** Error at %0t: %s expected %h, got %h", $time, name, exp_v, act_v);
    errors++;
  endtask

  task automatic note_failure(string what);
    $display("** Error at %0t: %s", $time, what);
    errors++;
  endtask

  // Advance one cycle to 1 ns after the edge
  task automatic next_cycle();
    @(posedge ap_clk);
    #1;
    if (req_credit) begin
      req_credits++;
      credit_pulses++;
    end
  endtask

  task automatic send_cmd(mcu_cmd_e cmd, logic [`MCU_ADDR_W-1:0] off,
      logic [`MCU_DATA_W-1:0] data, logic [`MCU_STRB_W-1:0] strb);
    mcu_operand_u           op;
    logic [`MCU_TAG_W-1:0]  tag;
    logic [`MCU_ADDR_W-1:0] addr;
    tag = `MCU_TAG_W'($urandom());
    if (cmd == CMD_WRITE) begin
      op.wr.wdata = data;
      op.wr.wstrb = strb;
    end else begin
      op.rd.tag  = tag;
      op.rd.pad  = '0;
      op.rd.mask = strb;
    end
    // Requester may only send while holding a credit
    while (req_credits == 0) next_cycle();
    addr = cur_base + off;
    expected.push_back(expect_rsp(cmd, addr, tag, op));
    if (cmd == CMD_WRITE) begin
      shadow[addr] = merge_bytes(shadow[addr], data, strb);
    end
    req_valid   = 1'b1;
    req_cmd     = cmd;
    req_offset  = off;
    // Struct tag of a read differs from its read-view tag
    req_tag     = (cmd == CMD_WRITE) ? tag : ~tag;
    req_operand = op;
    req_credits--;
    sent++;
    // Commands not yet issued on the memory port must fit the queue
    assert (sent - issued <= `MCU_REQ_DEPTH)
      else note_failure("request queue holds more commands than its depth");
    next_cycle();
    req_valid = 1'b0;
  endtask

  task automatic wait_drain();
    while (rsp_count != sent) next_cycle();
    // idle is registered behind the last response
    repeat (2) next_cycle();
    assert (idle) else note_failure("idle low after all responses drained");
  endtask

  task automatic close_test(string name, int mark);
    $display("%s finished with %0d errors", name, errors - mark);
  endtask

  // --------------------------------------------------------------------------
  // Memory model
  // --------------------------------------------------------------------------
  initial begin : memory_model
    logic [`MCU_ADDR_W-1:0] a;
    logic [`MCU_DATA_W-1:0] d;
    logic [`MCU_STRB_W-1:0] s;
    logic                   w;
    int                     lat;
    forever begin
      @(posedge ap_clk);
      #1;
      mem_done = 1'b0;
      if (mem_req) begin
        a   = mem_addr;
        w   = mem_we;
        d   = mem_wdata;
        s   = mem_wstrb;
        lat = $urandom_range(1, 4);
        // Reads carry no strobes
        if (!w) begin
          assert (s == '0)
            else flag_mismatch("mem_wstrb", 32'(0), 32'(s));
        end
        repeat (lat) begin
          @(posedge ap_clk);
          #1;
        end
        if (w) begin
          mem_model[a] = merge_bytes(mem_model[a], d, s);
        end
        // Read data valid in the mem_done cycle
        mem_rdata = mem_model[a];
        mem_done  = 1'b1;
      end
    end
  end

  // --------------------------------------------------------------------------
  // Consumer returning one credit per response taken
  // --------------------------------------------------------------------------
  initial begin : consumer
    int owed;
    int gap;
    bit hold_now;
    owed = 0;
    gap  = 0;
    forever begin
      @(posedge ap_clk);
      hold_now = hold_credits;
      #1;
      rsp_credit = 1'b0;
      if (rsp_valid) owed++;
      if (gap > 0) begin
        gap--;
      end else if (!hold_now && owed > 0) begin
        rsp_credit = 1'b1;
        owed--;
        gap = $urandom_range(0, 2);
      end
    end
  end

  // --------------------------------------------------------------------------
  // Compare process sampled mid-cycle
  // --------------------------------------------------------------------------
  always @(negedge ap_clk) begin
    logic [RSP_W-1:0] exp_rsp;
    if (!areset_control) begin
      if (rsp_credit) credits_back++;
      if (mem_req) issued++;
      if (rsp_valid) begin
        rsp_count++;
        assert (rsp_count <= `MCU_RSP_CREDITS + credits_back)
          else note_failure("more responses than response credits returned");
        if (expected.size() == 0) begin
          note_failure("response with no command outstanding");
        end else begin
          exp_rsp = expected.pop_front();
          assert (rsp_tag == exp_rsp[RSP_W-1 -: `MCU_TAG_W])
            else flag_mismatch("rsp_tag", 32'(exp_rsp[RSP_W-1 -: `MCU_TAG_W]), 32'(rsp_tag));
          assert (rsp_data == exp_rsp[`MCU_DATA_W-1:0])
            else flag_mismatch("rsp_data", exp_rsp[`MCU_DATA_W-1:0], rsp_data);
        end
      end
    end
  end

  // Cycle limit from worst case per command times command count
  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge ap_clk);
      cycles++;
    end
    $display("Run stopped at the %0d-cycle limit", MAX_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

  // --------------------------------------------------------------------------
  // Stimulus
  // --------------------------------------------------------------------------
  initial begin : stimulus
    int                     i;
    int                     mark;
    logic [`MCU_ADDR_W-1:0] a16;
    logic [`MCU_ADDR_W-1:0] off;
    void'($urandom(97531));
    areset_control = 1'b1;
    cfg_valid      = 1'b0;
    cfg_base       = '0;
    req_valid      = 1'b0;
    req_cmd        = CMD_READ;
    req_offset     = '0;
    req_tag        = '0;
    req_operand    = '0;
    rsp_credit     = 1'b0;
    mem_done       = 1'b0;
    mem_rdata      = '0;
    hold_credits   = 1'b0;
    for (i = 0; i < 2**`MCU_ADDR_W; i++) begin
      a16          = `MCU_ADDR_W'(i);
      mem_model[a16] = fill_word(a16);
      shadow[a16]    = fill_word(a16);
    end
    repeat (3) @(posedge ap_clk);
    #1;
    areset_control = 1'b0;
    next_cycle();
    assert (idle) else note_failure("idle low after reset");

    // Writes wait in the queue until a descriptor arrives
    mark     = errors;
    cur_base = `MCU_ADDR_W'($urandom());
    for (i = 0; i < 4; i++) send_cmd(CMD_WRITE, `MCU_ADDR_W'(i), $urandom(), 4'hf);
    repeat (20) next_cycle();
    assert (rsp_count == 0) else note_failure("response before a descriptor was loaded");
    assert (!idle) else note_failure("idle high with commands queued");
    cfg_valid = 1'b1;
    cfg_base  = cur_base;
    next_cycle();
    cfg_valid = 1'b0;
    wait_drain();
    close_test("descriptor_gate", mark);

    mark = errors;
    for (i = 0; i < 40; i++) begin
      send_cmd(CMD_WRITE, `MCU_ADDR_W'($urandom_range(0, 31)), $urandom(), 4'($urandom()));
    end
    wait_drain();
    close_test("write_echo", mark);

    mark = errors;
    for (i = 0; i < 40; i++) begin
      off = `MCU_ADDR_W'($urandom_range(0, 31));
      send_cmd(CMD_WRITE, off, $urandom(), 4'($urandom()));
      send_cmd(CMD_READ, off, '0, 4'($urandom()));
    end
    wait_drain();
    close_test("write_read_back", mark);

    // Full unit credits first, then the consumer holds them
    mark = errors;
    while (credits_back != rsp_count) next_cycle();
    hold_credits = 1'b1;
    for (i = 0; i < 2 * `MCU_REQ_DEPTH; i++) begin
      send_cmd(($urandom_range(0, 1) == 1) ? CMD_WRITE : CMD_READ,
               `MCU_ADDR_W'($urandom_range(0, 31)), $urandom(), 4'($urandom()));
    end
    repeat (40) next_cycle();
    assert (req_credits == 0) else note_failure("requester kept credits under back-pressure");
    hold_credits = 1'b0;
    wait_drain();
    close_test("credit_backpressure", mark);

    mark = errors;
    while (sent < NUM_CMDS) begin
      send_cmd(($urandom_range(0, 1) == 1) ? CMD_WRITE : CMD_READ,
               `MCU_ADDR_W'($urandom_range(0, 31)), $urandom(), 4'($urandom()));
    end
    wait_drain();
    close_test("random_mix", mark);

    assert (credit_pulses == sent)
      else note_failure("request credits returned differ from commands taken");
    errors += int'(dut_i.execute_i.props_i.fail_count);
    $display("Commands %0d, responses %0d, errors %0d", sent, rsp_count, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: list.f
+incdir+design
design/mcu_pkg.sv
design/mcu_decode.sv
design/mcu_execute.sv
design/mcu_result.sv
design/mcu_top.sv
bench/mcu_properties.sv
bench/mcu_tb.sv

// File: Makefile
# Verilator flow for the memory command unit testbench
TOP = mcu_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f list.f --top-module $(TOP)

# Error limit raised so bound assertion failures reach the final report
sim:
	verilator --binary --timing --assert -f list.f --top-module $(TOP) -o $(TOP)_sim
	-./obj_dir/$(TOP)_sim +verilator+error+limit+1000 > sim.log 2>&1
	cat sim.log
	@if grep -q "TEST FAILED" sim.log; then echo "Simulation reported a failure"; exit 1; fi
	@grep -q "TEST OK" sim.log || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf obj_dir sim.log
